// File: verilog/fma_cfg.svh
// Binary16 only. The derived widths follow from the base macros, so change those as a set
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// Encoding of the one supported format
`define FMA_EXP_BITS 5
`define FMA_MAN_BITS 10
`define FMA_WIDTH 16
`define FMA_BIAS 15

// Datapath sizes, p includes the implicit bit
`define FMA_PREC_BITS 11
`define FMA_SUM_WIDTH (3*`FMA_PREC_BITS+4)
`define FMA_LOWER_SUM_WIDTH (2*`FMA_PREC_BITS+3)
`define FMA_LZC_WIDTH $clog2(`FMA_LOWER_SUM_WIDTH)
`define FMA_EXP_WIDTH ((`FMA_EXP_BITS+2 > `FMA_LZC_WIDTH) ? `FMA_EXP_BITS+2 : `FMA_LZC_WIDTH)
`define FMA_SHAMT_WIDTH $clog2(3*`FMA_PREC_BITS+3)

`endif

// File: verilog/fma_pkg.sv
// Types for the binary16 FMA. Rounding mode codes follow RISC-V frm, and the DYN code is not decoded
`default_nettype none

`include "fma_cfg.svh"

package fma_pkg;

  typedef enum logic [1:0] {
    FMADD,  // a*b+c, op_mod gives FMSUB
    FNMSUB, // -a*b+c, op_mod gives FNMADD
    ADD,    // 1*b+c
    MUL     // a*b+(-0)
  } fma_op_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  // Accrued exception flags in fflags order
  typedef struct packed {
    logic nv;
    logic dz; // No division here, always zero
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // ----------------------------------------------------------
  // Payload carried from the adder to normalization
  // ----------------------------------------------------------
  typedef struct packed {
    logic                            effective_subtraction;
    logic                            final_sign;
    logic [`FMA_EXP_WIDTH-1:0]       exponent_product;    // Signed
    logic [`FMA_EXP_WIDTH-1:0]       exponent_difference; // Signed
    logic [`FMA_EXP_WIDTH-1:0]       tentative_exponent;  // Signed
    logic [`FMA_SHAMT_WIDTH-1:0]     addend_shamt;
    logic                            sticky_before_add;
    logic [`FMA_SUM_WIDTH-1:0]       sum;
    round_mode_e                     rnd_mode;
    logic                            result_is_special;
    logic [`FMA_WIDTH-1:0]           special_result;
    fp_status_t                      special_status;
  } align_stage_t;

endpackage

`default_nettype wire

// File: verilog/fma_operand_prep.sv
// Binary16 operands only. NaN results are always the canonical qNaN 7E00 and payloads are dropped
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_operand_prep import fma_pkg::*; (
  input  wire logic [`FMA_WIDTH-1:0]     operand_a_i,
  input  wire logic [`FMA_WIDTH-1:0]     operand_b_i,
  input  wire logic [`FMA_WIDTH-1:0]     operand_c_i,
  input  wire fma_op_e                   op_i,
  input  wire logic                      op_mod_i,
  output logic                           sign_a_o,
  output logic                           sign_b_o,
  output logic                           sign_c_o,
  output logic [`FMA_EXP_BITS-1:0]       exp_a_o,
  output logic [`FMA_EXP_BITS-1:0]       exp_b_o,
  output logic [`FMA_EXP_BITS-1:0]       exp_c_o,
  output logic [`FMA_PREC_BITS-1:0]      mant_a_o,
  output logic [`FMA_PREC_BITS-1:0]      mant_b_o,
  output logic [`FMA_PREC_BITS-1:0]      mant_c_o,
  output logic                           subnormal_a_o,
  output logic                           subnormal_b_o,
  output logic                           normal_c_o,
  output logic                           zero_ab_o,
  output logic                           result_is_special_o,
  output logic [`FMA_WIDTH-1:0]          special_result_o,
  output fp_status_t                     special_status_o
);

  localparam logic [`FMA_WIDTH-1:0] ONE      = `FMA_WIDTH'(`FMA_BIAS) << `FMA_MAN_BITS;
  localparam logic [`FMA_WIDTH-1:0] NEG_ZERO = {1'b1, {(`FMA_WIDTH-1){1'b0}}};
  localparam logic [`FMA_WIDTH-1:0] QNAN     =
      {1'b0, {`FMA_EXP_BITS{1'b1}}, 1'b1, {(`FMA_MAN_BITS-1){1'b0}}};

  logic [2:0][`FMA_WIDTH-1:0] ops; // Adjusted operands, index 0 is a
  logic [2:0] is_zero, is_normal, is_inf, is_nan, is_snan;
  logic       effective_subtraction;
  logic       product_inf;

  // ----------------------------------------------------------
  // Operation adjustment on the raw encodings
  // ----------------------------------------------------------
  // ADD forces a to +1.0, MUL forces c to -0 so RDN keeps exact zeros right
  assign ops[0] = (op_i == ADD) ? ONE
                : {operand_a_i[`FMA_WIDTH-1] ^ (op_i == FNMSUB), operand_a_i[`FMA_WIDTH-2:0]};
  assign ops[1] = operand_b_i;
  assign ops[2] = (op_i == MUL) ? NEG_ZERO
                : {operand_c_i[`FMA_WIDTH-1] ^ op_mod_i, operand_c_i[`FMA_WIDTH-2:0]};

  // Classification, one slice per operand
  for (genvar i = 0; i < 3; i++) begin : gen_classify
    logic exp_zero, exp_ones, man_zero;
    assign exp_zero   = (ops[i][`FMA_MAN_BITS +: `FMA_EXP_BITS] == '0);
    assign exp_ones   = (ops[i][`FMA_MAN_BITS +: `FMA_EXP_BITS] == '1);
    assign man_zero   = (ops[i][`FMA_MAN_BITS-1:0] == '0);
    assign is_zero[i]   = exp_zero & man_zero;
    assign is_normal[i] = ~exp_zero & ~exp_ones;
    assign is_inf[i]    = exp_ones & man_zero;
    assign is_nan[i]    = exp_ones & ~man_zero;
    assign is_snan[i]   = is_nan[i] & ~ops[i][`FMA_MAN_BITS-1]; // Quiet bit clear
  end

  assign sign_a_o = ops[0][`FMA_WIDTH-1];
  assign sign_b_o = ops[1][`FMA_WIDTH-1];
  assign sign_c_o = ops[2][`FMA_WIDTH-1];
  assign exp_a_o  = ops[0][`FMA_MAN_BITS +: `FMA_EXP_BITS];
  assign exp_b_o  = ops[1][`FMA_MAN_BITS +: `FMA_EXP_BITS];
  assign exp_c_o  = ops[2][`FMA_MAN_BITS +: `FMA_EXP_BITS];
  assign mant_a_o = {is_normal[0], ops[0][`FMA_MAN_BITS-1:0]}; // Implicit bit from class
  assign mant_b_o = {is_normal[1], ops[1][`FMA_MAN_BITS-1:0]};
  assign mant_c_o = {is_normal[2], ops[2][`FMA_MAN_BITS-1:0]};

  assign subnormal_a_o = (exp_a_o == '0) & ~is_zero[0];
  assign subnormal_b_o = (exp_b_o == '0) & ~is_zero[1];
  assign normal_c_o    = is_normal[2];
  assign zero_ab_o     = is_zero[0] | is_zero[1];

  assign effective_subtraction = sign_a_o ^ sign_b_o ^ sign_c_o;
  assign product_inf           = is_inf[0] | is_inf[1];

  // ----------------------------------------------------------
  // Special cases, highest priority first
  // ----------------------------------------------------------
  always_comb begin : special_case
    result_is_special_o = 1'b0;
    special_result_o    = QNAN;
    special_status_o    = '0;
    if ((is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1])) begin
      result_is_special_o = 1'b1;       // inf*0 is invalid even with a quiet NaN addend
      special_status_o.nv = 1'b1;
    end else if (|is_nan) begin
      result_is_special_o = 1'b1;
      special_status_o.nv = |is_snan;   // Only signalling inputs are invalid
    end else if (product_inf || is_inf[2]) begin
      result_is_special_o = 1'b1;
      if (product_inf && is_inf[2] && effective_subtraction) begin
        special_status_o.nv = 1'b1;     // inf - inf
      end else if (product_inf) begin
        special_result_o = {sign_a_o ^ sign_b_o, {`FMA_EXP_BITS{1'b1}}, {`FMA_MAN_BITS{1'b0}}};
      end else begin
        special_result_o = {sign_c_o, {`FMA_EXP_BITS{1'b1}}, {`FMA_MAN_BITS{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fma_align_mult.sv
// Assumes fields from fma_operand_prep. Results of the adder are only meaningful for finite inputs
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_align_mult import fma_pkg::*; (
  input  wire logic                      sign_a_i,
  input  wire logic                      sign_b_i,
  input  wire logic                      sign_c_i,
  input  wire logic [`FMA_EXP_BITS-1:0]  exp_a_i,
  input  wire logic [`FMA_EXP_BITS-1:0]  exp_b_i,
  input  wire logic [`FMA_EXP_BITS-1:0]  exp_c_i,
  input  wire logic [`FMA_PREC_BITS-1:0] mant_a_i,
  input  wire logic [`FMA_PREC_BITS-1:0] mant_b_i,
  input  wire logic [`FMA_PREC_BITS-1:0] mant_c_i,
  input  wire logic                      subnormal_a_i,
  input  wire logic                      subnormal_b_i,
  input  wire logic                      normal_c_i,
  input  wire logic                      zero_ab_i,
  input  wire logic                      result_is_special_i,
  input  wire logic [`FMA_WIDTH-1:0]     special_result_i,
  input  wire fp_status_t                special_status_i,
  input  wire round_mode_e               rnd_mode_i,
  output align_stage_t                   stage_o
);

  localparam int unsigned P   = `FMA_PREC_BITS;
  localparam int unsigned SW  = `FMA_SUM_WIDTH;
  localparam int unsigned EW  = `FMA_EXP_WIDTH;
  localparam int unsigned SHW = `FMA_SHAMT_WIDTH;

  logic signed [EW-1:0] exponent_a, exponent_b, exponent_c;
  logic signed [EW-1:0] exponent_addend, exponent_product, exponent_difference;
  logic signed [EW-1:0] tentative_exponent;
  logic [SHW-1:0]       addend_shamt;
  logic                 effective_subtraction, tentative_sign;

  logic [2*P-1:0] product;            // p*p gives 2p bits
  logic [SW-1:0]  product_shifted;
  logic [SW-1:0]  addend_after_shift;
  logic [P-1:0]   addend_sticky_bits; // Up to p bits fall off the right
  logic [SW-1:0]  addend_shifted;
  logic           sticky_before_add, inject_carry_in;
  logic [SW:0]    sum_raw, sum_neg;   // One extra bit for the carry

  assign effective_subtraction = sign_a_i ^ sign_b_i ^ sign_c_i;
  assign tentative_sign        = sign_a_i ^ sign_b_i; // Guess the product sign wins

  // ----------------------------------------------------------
  // Exponent datapath
  // ----------------------------------------------------------
  assign exponent_a = {{(EW-`FMA_EXP_BITS){1'b0}}, exp_a_i};
  assign exponent_b = {{(EW-`FMA_EXP_BITS){1'b0}}, exp_b_i};
  assign exponent_c = {{(EW-`FMA_EXP_BITS){1'b0}}, exp_c_i};

  // Subnormals act as exponent 1
  assign exponent_addend  = exponent_c + {{(EW-1){1'b0}}, ~normal_c_i};
  assign exponent_product = zero_ab_i ? EW'(2 - `FMA_BIAS)  // Zero product sits at the bottom
                          : exponent_a + EW'(subnormal_a_i) + exponent_b + EW'(subnormal_b_i)
                            - EW'(`FMA_BIAS);
  assign exponent_difference = exponent_addend - exponent_product;
  assign tentative_exponent  = (exponent_difference > 0) ? exponent_addend : exponent_product;

  always_comb begin : addend_shift_amount
    if (exponent_difference <= -2 * int'(P) - 1)
      addend_shamt = SHW'(3 * P + 4);                          // Addend only in sticky
    else if (exponent_difference <= int'(P) + 2)
      addend_shamt = SHW'(int'(P) + 3 - exponent_difference);  // Overlapping bits
    else
      addend_shamt = '0;                                       // Product only in sticky
  end

  // ----------------------------------------------------------
  // Product and addend alignment
  // ----------------------------------------------------------
  assign product         = mant_a_i * mant_b_i;
  assign product_shifted = {{(P+2){1'b0}}, product, 2'b00}; // Round and sticky room

  // Start the addend left of the whole field, then shift right
  assign {addend_after_shift, addend_sticky_bits} = {mant_c_i, {SW{1'b0}}} >> addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;

  assign addend_shifted  = effective_subtraction ? ~addend_after_shift : addend_after_shift;
  assign inject_carry_in = effective_subtraction & ~sticky_before_add; // Two's complement +1

  assign sum_raw = product_shifted + addend_shifted + (SW+1)'(inject_carry_in);
  assign sum_neg = ~sum_raw + 1'b1;

  always_comb begin : pack_stage
    stage_o.effective_subtraction = effective_subtraction;
    // A missing carry on subtraction means the addend was larger
    stage_o.final_sign = effective_subtraction ? (sum_raw[SW] == tentative_sign)
                                               : tentative_sign;
    stage_o.exponent_product    = exponent_product;
    stage_o.exponent_difference = exponent_difference;
    stage_o.tentative_exponent  = tentative_exponent;
    stage_o.addend_shamt        = addend_shamt;
    stage_o.sticky_before_add   = sticky_before_add;
    stage_o.sum = (effective_subtraction && !sum_raw[SW]) ? sum_neg[SW-1:0] : sum_raw[SW-1:0];
    stage_o.rnd_mode            = rnd_mode_i;
    stage_o.result_is_special   = result_is_special_i;
    stage_o.special_result      = special_result_i;
    stage_o.special_status      = special_status_i;
  end

endmodule

`default_nettype wire

// File: verilog/fma_pipe_reg.sv
// One-entry valid/ready slot. ready_o depends combinationally on ready_i
`timescale 1ns/100ps
`default_nettype none

module fma_pipe_reg #(
  parameter int unsigned DATA_WIDTH = 16
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  valid_i,
  output logic                       ready_o,
  input  wire logic [DATA_WIDTH-1:0] data_i,
  output logic                       valid_o,
  input  wire logic                  ready_i,
  output logic [DATA_WIDTH-1:0]      data_o
);

  logic                  valid_q;
  logic [DATA_WIDTH-1:0] data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= valid_i; // Bubble if nothing arrives
  end

  always_ff @(posedge clk_i) begin
    if (ready_o)
      data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: verilog/fma_norm_round.sv
// Binary16 result path. Underflow is detected after rounding, as RISC-V requires
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_norm_round import fma_pkg::*; (
  input  wire align_stage_t          stage_i,
  output logic [`FMA_WIDTH-1:0]      result_o,
  output fp_status_t                 status_o
);

  localparam int unsigned P   = `FMA_PREC_BITS;
  localparam int unsigned SW  = `FMA_SUM_WIDTH;
  localparam int unsigned LSW = `FMA_LOWER_SUM_WIDTH;
  localparam int unsigned LZW = `FMA_LZC_WIDTH;
  localparam int unsigned EW  = `FMA_EXP_WIDTH;
  localparam int unsigned SHW = `FMA_SHAMT_WIDTH;
  localparam int unsigned AW  = `FMA_EXP_BITS + `FMA_MAN_BITS; // Magnitude width

  logic signed [EW-1:0] exponent_product, exponent_difference, tentative_exponent;
  logic [LSW-1:0]       sum_lower;
  logic [LZW-1:0]       leading_zero_count;
  logic signed [LZW:0]  leading_zero_count_sgn;
  logic                 lzc_zeroes;
  logic [SHW-1:0]       norm_shamt;
  logic signed [EW-1:0] normalized_exponent, final_exponent;
  logic [SW:0]          sum_shifted;       // Carry bit on top
  logic [P:0]           final_mantissa;    // Mantissa plus round bit
  logic [LSW-1:0]       sum_sticky_bits;
  logic                 sticky_after_norm;

  logic          of_before_round, of_after_round, uf_after_round;
  logic [AW-1:0] pre_round_abs, rounded_abs;
  logic [1:0]    round_sticky_bits;
  logic          round_up, result_zero, rounded_sign;
  logic [`FMA_WIDTH-1:0] regular_result;
  fp_status_t    regular_status;

  assign exponent_product    = stage_i.exponent_product;
  assign exponent_difference = stage_i.exponent_difference;
  assign tentative_exponent  = stage_i.tentative_exponent;

  // ----------------------------------------------------------
  // Leading-zero count over the lower 2p+3 bits
  // ----------------------------------------------------------
  assign sum_lower  = stage_i.sum[LSW-1:0];
  assign lzc_zeroes = ~|sum_lower;

  always_comb begin : lzc
    leading_zero_count = '0;
    for (int i = 0; i < LSW; i++) begin
      if (sum_lower[i])
        leading_zero_count = LZW'(LSW - 1 - i); // Highest set bit wins
    end
  end

  assign leading_zero_count_sgn = signed'({1'b0, leading_zero_count});

  always_comb begin : norm_shift_amount
    if ((exponent_difference <= 0) ||
        (stage_i.effective_subtraction && (exponent_difference <= 2))) begin
      // Product anchored or heavy cancellation
      if ((exponent_product - leading_zero_count_sgn + 1 >= 0) && !lzc_zeroes) begin
        norm_shamt          = SHW'(P + 2 + leading_zero_count);
        normalized_exponent = EW'(exponent_product - leading_zero_count_sgn + 1);
      end else begin
        norm_shamt          = SHW'(int'(P) + 2 + exponent_product); // Capped at subnormal
        normalized_exponent = '0;
      end
    end else begin
      norm_shamt          = stage_i.addend_shamt; // Addend anchored, undo alignment
      normalized_exponent = tentative_exponent;
    end
  end

  assign sum_shifted = {1'b0, stage_i.sum} << norm_shamt;

  // Leading one may still sit one place off
  always_comb begin : small_norm
    {final_mantissa, sum_sticky_bits} = sum_shifted[SW-1:0];
    final_exponent                    = normalized_exponent;
    if (sum_shifted[SW]) begin
      {final_mantissa, sum_sticky_bits} = sum_shifted[SW:1];
      final_exponent                    = normalized_exponent + 1'b1;
    end else if (sum_shifted[SW-1]) begin
      final_exponent = normalized_exponent; // Already normal
    end else if (normalized_exponent > 1) begin
      {final_mantissa, sum_sticky_bits} = {sum_shifted[SW-2:0], 1'b0};
      final_exponent                    = normalized_exponent - 1'b1;
    end else begin
      final_exponent = '0; // Subnormal
    end
  end

  assign sticky_after_norm = (|sum_sticky_bits) | stage_i.sticky_before_add;

  // ----------------------------------------------------------
  // Rounding and flags
  // ----------------------------------------------------------
  assign of_before_round = final_exponent >= 2**`FMA_EXP_BITS - 1;

  // Overflow saturates to max finite and lets the rounder decide on infinity
  assign pre_round_abs = of_before_round ? {{(`FMA_EXP_BITS-1){1'b1}}, 1'b0, {`FMA_MAN_BITS{1'b1}}}
                       : {final_exponent[`FMA_EXP_BITS-1:0], final_mantissa[P-1:1]};
  assign round_sticky_bits = {final_mantissa[0] | of_before_round,
                              sticky_after_norm | of_before_round};

  always_comb begin : round_decision
    unique case (stage_i.rnd_mode)
      RNE:     round_up = round_sticky_bits[1] & (round_sticky_bits[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_bits) & stage_i.final_sign;
      RUP:     round_up = (|round_sticky_bits) & ~stage_i.final_sign;
      RMM:     round_up = round_sticky_bits[1]; // Ties away from zero
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + AW'(round_up);       // Carry may bump the exponent
  assign result_zero = (pre_round_abs == '0) && (round_sticky_bits == 2'b00);
  // Exact cancellation is +0, or -0 when rounding down
  assign rounded_sign = (result_zero && stage_i.effective_subtraction)
                      ? (stage_i.rnd_mode == RDN) : stage_i.final_sign;

  assign of_after_round = (rounded_abs[AW-1:`FMA_MAN_BITS] == '1);
  assign uf_after_round = (rounded_abs[AW-1:`FMA_MAN_BITS] == '0) & ~result_zero;

  assign regular_result    = {rounded_sign, rounded_abs};
  assign regular_status.nv = 1'b0;
  assign regular_status.dz = 1'b0;
  assign regular_status.of = of_before_round | of_after_round;
  assign regular_status.uf = uf_after_round;
  assign regular_status.nx = (|round_sticky_bits) | of_before_round | of_after_round;

  assign result_o = stage_i.result_is_special ? stage_i.special_result : regular_result;
  assign status_o = stage_i.result_is_special ? stage_i.special_status : regular_status;

endmodule

`default_nettype wire

// File: verilog/fma_unit.sv
// Two-stage binary16 FMA with valid/ready at both ends. in_ready_o follows out_ready_i combinationally
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_unit import fma_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic [`FMA_WIDTH-1:0] operand_a_i,
  input  wire logic [`FMA_WIDTH-1:0] operand_b_i,
  input  wire logic [`FMA_WIDTH-1:0] operand_c_i,
  input  wire fma_op_e               op_i,
  input  wire logic                  op_mod_i,
  input  wire round_mode_e           rnd_mode_i,
  input  wire logic                  in_valid_i,
  output logic                       in_ready_o,
  output logic [`FMA_WIDTH-1:0]      result_o,
  output fp_status_t                 status_o,
  output logic                       out_valid_o,
  input  wire logic                  out_ready_i
);

  localparam int unsigned OUT_WIDTH = `FMA_WIDTH + $bits(fp_status_t);

  logic                       sign_a, sign_b, sign_c;
  logic [`FMA_EXP_BITS-1:0]   exp_a, exp_b, exp_c;
  logic [`FMA_PREC_BITS-1:0]  mant_a, mant_b, mant_c;
  logic                       subnormal_a, subnormal_b, normal_c, zero_ab;
  logic                       result_is_special;
  logic [`FMA_WIDTH-1:0]      special_result, norm_result;
  fp_status_t                 special_status, norm_status;
  align_stage_t               stage1_d, stage1_q;
  logic                       stage1_valid, stage2_ready;
  logic [OUT_WIDTH-1:0]       stage2_d, stage2_q;

  // ----------------------------------------------------------
  // Stage 1 logic: unpack, multiply, align, add
  // ----------------------------------------------------------
  fma_operand_prep u_prep (
    .operand_a_i, .operand_b_i, .operand_c_i, .op_i, .op_mod_i,
    .sign_a_o (sign_a), .sign_b_o (sign_b), .sign_c_o (sign_c),
    .exp_a_o (exp_a), .exp_b_o (exp_b), .exp_c_o (exp_c),
    .mant_a_o (mant_a), .mant_b_o (mant_b), .mant_c_o (mant_c),
    .subnormal_a_o (subnormal_a), .subnormal_b_o (subnormal_b),
    .normal_c_o (normal_c), .zero_ab_o (zero_ab),
    .result_is_special_o (result_is_special),
    .special_result_o (special_result), .special_status_o (special_status)
  );

  fma_align_mult u_align (
    .sign_a_i (sign_a), .sign_b_i (sign_b), .sign_c_i (sign_c),
    .exp_a_i (exp_a), .exp_b_i (exp_b), .exp_c_i (exp_c),
    .mant_a_i (mant_a), .mant_b_i (mant_b), .mant_c_i (mant_c),
    .subnormal_a_i (subnormal_a), .subnormal_b_i (subnormal_b),
    .normal_c_i (normal_c), .zero_ab_i (zero_ab),
    .result_is_special_i (result_is_special),
    .special_result_i (special_result), .special_status_i (special_status),
    .rnd_mode_i, .stage_o (stage1_d)
  );

  fma_pipe_reg #(.DATA_WIDTH ($bits(align_stage_t))) u_stage1 (
    .clk_i, .rst_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (stage1_d),
    .valid_o (stage1_valid), .ready_i (stage2_ready), .data_o (stage1_q)
  );

  // ----------------------------------------------------------
  // Stage 2 logic: normalize, round, pick special result
  // ----------------------------------------------------------
  fma_norm_round u_norm (
    .stage_i (stage1_q), .result_o (norm_result), .status_o (norm_status)
  );

  assign stage2_d = {norm_result, norm_status};

  fma_pipe_reg #(.DATA_WIDTH (OUT_WIDTH)) u_stage2 (
    .clk_i, .rst_i,
    .valid_i (stage1_valid), .ready_o (stage2_ready), .data_i (stage2_d),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (stage2_q)
  );

  assign {result_o, status_o} = stage2_q;

endmodule

`default_nettype wire

// File: tests/fma_unit_properties.sv
// Handshake checks for fma_unit. Sampled on clk_i, so glitches between edges are not seen
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_unit_properties import fma_pkg::*; (
  input wire logic                  clk_i,
  input wire logic                  rst_i,
  input wire logic                  in_ready_o,
  input wire logic                  out_valid_o,
  input wire logic                  out_ready_i,
  input wire logic [`FMA_WIDTH-1:0] result_o,
  input wire fp_status_t            status_o
);

  // Output slot is empty during reset and in the cycle after it
  out_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else $error("out_valid_o high during or right after reset");

  // Stalled output keeps its data
  out_stable_when_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(status_o))
    else $error("Output changed while stalled by out_ready_i");

  // Input can only back up when both slots hold data
  in_stall_needs_output: assert property (@(posedge clk_i) disable iff (rst_i)
      !in_ready_o |-> out_valid_o)
    else $error("in_ready_o low while out_valid_o is low");

endmodule

bind fma_unit fma_unit_properties u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .status_o    (status_o)
);

`default_nettype wire

// File: tests/fma_unit_tb.sv
// Directed binary16 vectors with random output stall. Expected values are hand computed
`timescale 1ns/100ps
`default_nettype none

`include "fma_cfg.svh"

module fma_unit_tb import fma_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int SETTLE       = CLK_PERIOD / 4; // Sample point after the falling edge
  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_CYCLES = 8;              // Idle time after the last expected result
  localparam int NUM_VECTORS  = 26;

  localparam fp_status_t ST_NONE  = 5'b00000;
  localparam fp_status_t ST_NV    = 5'b10000;
  localparam fp_status_t ST_NX    = 5'b00001;
  localparam fp_status_t ST_OF_NX = 5'b00101;
  localparam fp_status_t ST_UF_NX = 5'b00011;

  typedef struct packed {
    logic [`FMA_WIDTH-1:0] a;
    logic [`FMA_WIDTH-1:0] b;
    logic [`FMA_WIDTH-1:0] c;
    fma_op_e               op;
    logic                  op_mod;
    round_mode_e           rnd;
    logic [`FMA_WIDTH-1:0] result;
    fp_status_t            status;
  } vector_t;

  logic                  clk_i, rst_i;
  logic [`FMA_WIDTH-1:0] operand_a_i, operand_b_i, operand_c_i;
  fma_op_e               op_i;
  logic                  op_mod_i;
  round_mode_e           rnd_mode_i;
  logic                  in_valid_i, in_ready_o;
  logic [`FMA_WIDTH-1:0] result_o;
  fp_status_t            status_o;
  logic                  out_valid_o, out_ready_i;

  vector_t vectors [NUM_VECTORS];
  int      num_loaded = 0;
  int      pending [$];  // Indices of accepted vectors, oldest first
  int      errors = 0;
  int      received = 0;
  int      check_idx;
  integer  seed = 32'h4293597b;

  fma_unit uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Vector table
  // ----------------------------------------------------------
  task automatic add_vector(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                            input fma_op_e op, input logic op_mod, input round_mode_e rnd,
                            input logic [15:0] result, input fp_status_t status);
    vectors[num_loaded] = '{a, b, c, op, op_mod, rnd, result, status};
    num_loaded++;
  endtask

  task automatic load_table();
    add_vector(16'h3C00, 16'h4000, 16'h3800, FMADD,  1'b0, RNE, 16'h4100, ST_NONE); // 1*2+0.5
    add_vector(16'h4000, 16'h4200, 16'h3C00, FMADD,  1'b1, RNE, 16'h4500, ST_NONE); // 2*3-1
    add_vector(16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b0, RNE, 16'hC500, ST_NONE); // -6+1
    add_vector(16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b1, RNE, 16'hC700, ST_NONE); // -6-1
    add_vector(16'h3C00, 16'h3800, 16'hC000, FMADD,  1'b0, RNE, 16'hBE00, ST_NONE); // Addend wins
    add_vector(16'h1234, 16'h3E00, 16'h4100, ADD,    1'b0, RNE, 16'h4400, ST_NONE); // 1.5+2.5
    add_vector(16'h0000, 16'h4200, 16'h3C00, ADD,    1'b1, RNE, 16'h4000, ST_NONE); // 3-1
    add_vector(16'h3E00, 16'h3E00, 16'h1234, MUL,    1'b0, RNE, 16'h4080, ST_NONE); // 1.5*1.5
    add_vector(16'h0000, 16'h3C00, 16'h3C00, ADD,    1'b1, RNE, 16'h0000, ST_NONE); // 1-1
    add_vector(16'h0000, 16'h3C00, 16'h3C00, ADD,    1'b1, RDN, 16'h8000, ST_NONE);
    // 1 + half ulp is a tie, 1 + 0.75 ulp is not
    add_vector(16'h3C00, 16'h3C00, 16'h1000, FMADD,  1'b0, RNE, 16'h3C00, ST_NX);
    add_vector(16'h3C00, 16'h3C00, 16'h1000, FMADD,  1'b0, RMM, 16'h3C01, ST_NX);
    add_vector(16'h3C00, 16'h3C00, 16'h1200, FMADD,  1'b0, RTZ, 16'h3C00, ST_NX);
    add_vector(16'h3C00, 16'h3C00, 16'h1200, FMADD,  1'b0, RUP, 16'h3C01, ST_NX);
    add_vector(16'hBC00, 16'h3C00, 16'h9000, FMADD,  1'b0, RDN, 16'hBC01, ST_NX); // Negative tie
    add_vector(16'hBC00, 16'h3C00, 16'h9000, FMADD,  1'b0, RUP, 16'hBC00, ST_NX);
    add_vector(16'h7BFF, 16'h4000, 16'h0000, MUL,    1'b0, RNE, 16'h7C00, ST_OF_NX); // Max*2
    add_vector(16'h7BFF, 16'h4000, 16'h0000, MUL,    1'b0, RTZ, 16'h7BFF, ST_OF_NX);
    add_vector(16'hFBFF, 16'h4000, 16'h0000, MUL,    1'b0, RDN, 16'hFC00, ST_OF_NX);
    add_vector(16'h0401, 16'h3800, 16'h0000, MUL,    1'b0, RNE, 16'h0200, ST_UF_NX); // Tiny tie
    add_vector(16'h7C00, 16'h0000, 16'h3C00, FMADD,  1'b0, RNE, 16'h7E00, ST_NV);   // inf*0
    add_vector(16'h7E00, 16'h3C00, 16'h3C00, FMADD,  1'b0, RNE, 16'h7E00, ST_NONE); // qNaN
    add_vector(16'h3C00, 16'h3C00, 16'h7D00, FMADD,  1'b0, RNE, 16'h7E00, ST_NV);   // sNaN
    add_vector(16'h7C00, 16'h3C00, 16'h7C00, FMADD,  1'b1, RNE, 16'h7E00, ST_NV);   // inf-inf
    add_vector(16'hFC00, 16'h4000, 16'h3C00, FMADD,  1'b0, RNE, 16'hFC00, ST_NONE);
    add_vector(16'h0000, 16'h3C00, 16'hFC00, ADD,    1'b0, RNE, 16'hFC00, ST_NONE); // Addend inf
  endtask

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  task automatic apply_vector(input int idx);
    @(negedge clk_i);
    operand_a_i = vectors[idx].a;
    operand_b_i = vectors[idx].b;
    operand_c_i = vectors[idx].c;
    op_i        = vectors[idx].op;
    op_mod_i    = vectors[idx].op_mod;
    rnd_mode_i  = vectors[idx].rnd;
    in_valid_i  = 1'b1;
    #(SETTLE);
    while (!in_ready_o) begin  // Held until the next rising edge takes it
      @(negedge clk_i);
      #(SETTLE);
    end
    pending.push_back(idx);
  endtask

  // Output side with random back-pressure of about one stall in four
  initial begin : output_check
    forever begin
      @(negedge clk_i);
      out_ready_i = ({$random(seed)} % 4) != 0;
      #(SETTLE);
      if (!rst_i && out_valid_o && out_ready_i) begin
        if (pending.size() == 0) begin
          $display("Output transfer at %0t with no operation in flight", $time);
          errors++;
        end else begin
          check_idx = pending.pop_front();
          assert (result_o == vectors[check_idx].result
                  && status_o == vectors[check_idx].status) else begin
            $display("** Error at %0t: vector %0d gave %h flags %b, expected %h flags %b",
                     $time, check_idx, result_o, status_o,
                     vectors[check_idx].result, vectors[check_idx].status);
            errors++;
          end
          received++;
        end
      end
    end
  end

  initial begin : watchdog
    #((NUM_VECTORS * 20 + RESET_CYCLES + DRAIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d results came out", received, NUM_VECTORS);
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin : main
    rst_i       = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = FMADD;
    op_mod_i    = 1'b0;
    rnd_mode_i  = RNE;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    load_table();

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;
    #(SETTLE);
    assert (in_ready_o && !out_valid_o) else begin
      $display("** Error at %0t: handshake not idle after reset", $time);
      errors++;
    end

    for (int i = 0; i < NUM_VECTORS; i++)
      apply_vector(i);
    @(negedge clk_i);
    in_valid_i = 1'b0;

    while (received < NUM_VECTORS) @(negedge clk_i); // Wait for every result
    repeat (DRAIN_CYCLES) @(negedge clk_i);          // A duplicate shows up as an extra transfer

    $display("Results checked: %0d of %0d, errors: %0d", received, NUM_VECTORS, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fma_unit.f
+incdir+verilog
verilog/fma_pkg.sv
verilog/fma_operand_prep.sv
verilog/fma_align_mult.sv
verilog/fma_pipe_reg.sv
verilog/fma_norm_round.sv
verilog/fma_unit.sv
tests/fma_unit_properties.sv
tests/fma_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FMA testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    -f fma_unit.f --top-module fma_unit_tb -o fma_unit_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/fma_unit_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if ! grep -q "Regression passed" sim.log; then
  exit 1
fi
exit 0
